/* verilog/id_queue_pkg.sv */
// ====================
// ID queue package
// Index-width helpers and default sizes shared by the queue RTL
// ====================
`default_nettype none

package id_queue_pkg;

    // Default top-level sizes
    localparam int DefaultIdWidth   = 2;
    localparam int DefaultCapacity  = 4;
    localparam int DefaultDataWidth = 8;

    // Number of index bits for a table of the given entry count, never below one bit
    function automatic int idx_width(input int entries);
        return (entries > 1) ? $clog2(entries) : 1;
    endfunction

    // Head-tail table size: one entry per distinct ID, but never more IDs than cells
    function automatic int ht_capacity(input int id_width, input int capacity);
        int n_ids;
        n_ids = 1 << id_width;
        return (n_ids < capacity) ? n_ids : capacity;
    endfunction

endpackage

`default_nettype wire

/* verilog/id_queue_first_free.sv */
// ====================
// First free slot finder
// Priority encoder returning the lowest set free bit of a table
// ====================
`timescale 1ns/1ps
`default_nettype none

module id_queue_first_free
    import id_queue_pkg::*;
#(
    parameter int WIDTH = DefaultCapacity
) (
    input  logic [WIDTH-1:0]            free_i,
    output logic [idx_width(WIDTH)-1:0] idx_o,
    output logic                        found_o
);

    localparam int IdxWidth = idx_width(WIDTH);

    // Scan from the top down so that the last hit, the lowest index, wins
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IdxWidth'(i);
            end
        end
    end

    // Any free bit at all means a slot can be allocated
    assign found_o = |free_i;

    // The encoded index must always land on a slot that is really free
    always_comb begin
        assert final (!found_o || free_i[idx_o])
            else $error("First free index points at an occupied slot");
    end

endmodule

`default_nettype wire

/* verilog/id_queue_id_lookup.sv */
// ====================
// Head-tail ID lookup
// Finds the occupied head-tail entry that owns a given ID
// ====================
`timescale 1ns/1ps
`default_nettype none

module id_queue_id_lookup
    import id_queue_pkg::*;
#(
    parameter int ID_WIDTH = DefaultIdWidth,
    parameter int ENTRIES  = ht_capacity(ID_WIDTH, DefaultCapacity)
) (
    input  logic [ID_WIDTH-1:0]               lookup_id_i,
    input  logic                              lookup_valid_i,
    input  logic [ENTRIES-1:0][ID_WIDTH-1:0]  entry_ids_i,
    input  logic [ENTRIES-1:0]                entry_used_i,
    output logic                              hit_o,
    output logic [idx_width(ENTRIES)-1:0]     hit_idx_o
);

    localparam int IdxWidth = idx_width(ENTRIES);

    // One bit per head-tail entry, set where the stored ID matches
    logic [ENTRIES-1:0] match;

    // Free entries hold stale IDs, so only occupied ones may compare
    for (genvar i = 0; i < ENTRIES; i++) begin : gen_match
        assign match[i] = lookup_valid_i && entry_used_i[i] &&
                          (entry_ids_i[i] == lookup_id_i);
    end

    assign hit_o = |match;

    // One-hot to binary by ORing the indices of all set bits
    // With a one-hot match vector this yields exactly the matching index
    always_comb begin
        hit_idx_o = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (match[i]) begin
                hit_idx_o = hit_idx_o | IdxWidth'(i);
            end
        end
    end

    // The controller never opens a second entry for an ID it already tracks
    always_comb begin
        assert final ($onehot0(match))
            else $error("Two head-tail entries share one ID");
    end

endmodule

`default_nettype wire

/* verilog/id_queue_exists_search.sv */
// ====================
// Masked exists search
// Reports whether any occupied cell matches a value on the masked bits
// ====================
`timescale 1ns/1ps
`default_nettype none

module id_queue_exists_search
    import id_queue_pkg::*;
#(
    parameter int CAPACITY   = DefaultCapacity,
    parameter int DATA_WIDTH = DefaultDataWidth
) (
    input  logic [CAPACITY-1:0][DATA_WIDTH-1:0] cell_data_i,
    input  logic [CAPACITY-1:0]                 cell_used_i,
    input  logic                                req_i,
    input  logic [DATA_WIDTH-1:0]               data_i,
    input  logic [DATA_WIDTH-1:0]               mask_i,
    output logic                                match_o
);

    // Per-cell hit flags
    logic [CAPACITY-1:0] cell_hit;

    for (genvar i = 0; i < CAPACITY; i++) begin : gen_cell
        // Bits that differ from the search value, kept only where the mask is set
        logic [DATA_WIDTH-1:0] diff;

        assign diff = (cell_data_i[i] ^ data_i) & mask_i;

        // A free cell never matches, even under an all-zero mask
        assign cell_hit[i] = cell_used_i[i] && (diff == '0);
    end

    // Without a request the answer stays low
    assign match_o = req_i && (|cell_hit);

endmodule

`default_nettype wire

/* verilog/id_queue_ctrl.sv */
// ====================
// ID queue controller
// Holds the head-tail and linked data tables and applies push, peek and pop
// ====================
`timescale 1ns/1ps
`default_nettype none

module id_queue_ctrl
    import id_queue_pkg::*;
#(
    parameter int ID_WIDTH   = DefaultIdWidth,
    parameter int CAPACITY   = DefaultCapacity,
    parameter int DATA_WIDTH = DefaultDataWidth
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                inp_req_i,
    input  logic [ID_WIDTH-1:0]                 inp_id_i,
    input  logic [DATA_WIDTH-1:0]               inp_data_i,
    output logic                                inp_gnt_o,

    input  logic                                oup_req_i,
    input  logic [ID_WIDTH-1:0]                 oup_id_i,
    input  logic                                oup_pop_i,
    output logic                                oup_gnt_o,
    output logic [DATA_WIDTH-1:0]               oup_data_o,
    output logic                                oup_data_valid_o,

    output logic [CAPACITY-1:0][DATA_WIDTH-1:0] cell_data_o,
    output logic [CAPACITY-1:0]                 cell_used_o
);

    localparam int HtEntries  = ht_capacity(ID_WIDTH, CAPACITY);
    localparam int HtIdxWidth = idx_width(HtEntries);
    localparam int LdIdxWidth = idx_width(CAPACITY);

    // One entry per active ID, pointing at the oldest and newest cell of its list
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [LdIdxWidth-1:0] head;
        logic [LdIdxWidth-1:0] tail;
        logic                  free;
    } head_tail_t;

    // One data cell, chained to the next younger cell of the same ID
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [LdIdxWidth-1:0] next;
        logic                  free;
    } linked_data_t;

    head_tail_t   [HtEntries-1:0] head_tail_d, head_tail_q;
    linked_data_t [CAPACITY-1:0]  linked_data_d, linked_data_q;

    logic [HtEntries-1:0]               ht_free;
    logic [HtEntries-1:0][ID_WIDTH-1:0] ht_ids;
    logic [CAPACITY-1:0]                ld_free;

    logic [HtIdxWidth-1:0] ht_free_idx;
    logic                  ht_found;
    logic [LdIdxWidth-1:0] ld_free_idx;

    logic                  push_acc;
    logic [ID_WIDTH-1:0]   lookup_id;
    logic                  lookup_valid;
    logic                  hit;
    logic [HtIdxWidth-1:0] hit_idx;
    logic [LdIdxWidth-1:0] pop_head;

    // Flatten table fields for the search helpers and the exported state
    for (genvar i = 0; i < HtEntries; i++) begin : gen_ht_flat
        assign ht_free[i] = head_tail_q[i].free;
        assign ht_ids[i]  = head_tail_q[i].id;
    end

    for (genvar i = 0; i < CAPACITY; i++) begin : gen_ld_flat
        assign ld_free[i]     = linked_data_q[i].free;
        assign cell_used_o[i] = !linked_data_q[i].free;
        assign cell_data_o[i] = linked_data_q[i].data;
    end

    id_queue_first_free #(
        .WIDTH   (HtEntries)
    ) u_ht_free (
        .free_i  (ht_free),
        .idx_o   (ht_free_idx),
        .found_o (ht_found)
    );

    // A push is granted exactly when a data cell is free
    id_queue_first_free #(
        .WIDTH   (CAPACITY)
    ) u_ld_free (
        .free_i  (ld_free),
        .idx_o   (ld_free_idx),
        .found_o (inp_gnt_o)
    );

    // Push has priority, so an accepted push takes the single ID matcher
    assign push_acc     = inp_req_i && inp_gnt_o;
    assign lookup_id    = push_acc ? inp_id_i : oup_id_i;
    assign lookup_valid = push_acc || oup_req_i;
    assign oup_gnt_o    = oup_req_i && !push_acc;

    id_queue_id_lookup #(
        .ID_WIDTH       (ID_WIDTH),
        .ENTRIES        (HtEntries)
    ) u_id_lookup (
        .lookup_id_i    (lookup_id),
        .lookup_valid_i (lookup_valid),
        .entry_ids_i    (ht_ids),
        .entry_used_i   (~ht_free),
        .hit_o          (hit),
        .hit_idx_o      (hit_idx)
    );

    // Oldest cell of the ID being served on the output port
    assign pop_head = head_tail_q[hit_idx].head;

    always_comb begin
        head_tail_d      = head_tail_q;
        linked_data_d    = linked_data_q;
        oup_data_o       = '0;
        oup_data_valid_o = 1'b0;

        if (push_acc) begin
            if (!hit) begin
                // First element of this ID opens a fresh head-tail entry
                head_tail_d[ht_free_idx] = '{
                    id:   inp_id_i,
                    head: ld_free_idx,
                    tail: ld_free_idx,
                    free: 1'b0
                };
            end else begin
                // Chain the new cell behind the current tail of the ID
                linked_data_d[head_tail_q[hit_idx].tail].next = ld_free_idx;
                head_tail_d[hit_idx].tail = ld_free_idx;
            end
            linked_data_d[ld_free_idx] = '{data: inp_data_i, next: '0, free: 1'b0};
        end else if (oup_req_i && hit) begin
            oup_data_o       = linked_data_q[pop_head].data;
            oup_data_valid_o = 1'b1;
            if (oup_pop_i) begin
                linked_data_d[pop_head] = '{free: 1'b1, default: '0};
                // The last element of an ID also releases its head-tail entry
                if (pop_head == head_tail_q[hit_idx].tail) begin
                    head_tail_d[hit_idx] = '{free: 1'b1, default: '0};
                end else begin
                    head_tail_d[hit_idx].head = linked_data_q[pop_head].next;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_tail_q   <= {HtEntries{head_tail_t'{free: 1'b1, default: '0}}};
            linked_data_q <= {CAPACITY{linked_data_t'{free: 1'b1, default: '0}}};
        end else begin
            head_tail_q   <= head_tail_d;
            linked_data_q <= linked_data_d;
        end
    end

    // The head pointer of a live ID must never refer to a released cell
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (oup_gnt_o && oup_data_valid_o && oup_pop_i) |-> !linked_data_q[pop_head].free)
        else $error("Pop would release a cell that is already free");

    // Pops and refused pushes never take a cell, so only an accepted push
    // can use up the last free cell and withdraw the push grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(inp_gnt_o) |-> $past(push_acc))
        else $error("Push grant dropped without a push taking the last free cell");

    // A free data cell implies room for a new ID, since IDs never outnumber cells
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_acc && !hit) |-> ht_found)
        else $error("No head-tail entry left for a new ID");

endmodule

`default_nettype wire

/* verilog/id_queue.sv */
// ====================
// ID queue
// Per-ID FIFO storage with push, peek, pop and a masked exists search
// ====================
`timescale 1ns/1ps
`default_nettype none

module id_queue
    import id_queue_pkg::*;
#(
    parameter int ID_WIDTH   = DefaultIdWidth,
    parameter int CAPACITY   = DefaultCapacity,
    parameter int DATA_WIDTH = DefaultDataWidth
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  inp_req_i,
    input  logic [ID_WIDTH-1:0]   inp_id_i,
    input  logic [DATA_WIDTH-1:0] inp_data_i,
    output logic                  inp_gnt_o,

    input  logic                  exists_req_i,
    input  logic [DATA_WIDTH-1:0] exists_data_i,
    input  logic [DATA_WIDTH-1:0] exists_mask_i,
    output logic                  exists_gnt_o,
    output logic                  exists_o,

    input  logic                  oup_req_i,
    input  logic [ID_WIDTH-1:0]   oup_id_i,
    input  logic                  oup_pop_i,
    output logic                  oup_gnt_o,
    output logic [DATA_WIDTH-1:0] oup_data_o,
    output logic                  oup_data_valid_o
);

    // Stored cells as seen by the exists search
    logic [CAPACITY-1:0][DATA_WIDTH-1:0] cell_data;
    logic [CAPACITY-1:0]                 cell_used;

    // Reject sizes that leave either table without entries
    if (ID_WIDTH < 1 || ht_capacity(ID_WIDTH, CAPACITY) < 1) begin : gen_param_check
        $fatal(1, "ID width and capacity must both be at least one");
    end

    id_queue_ctrl #(
        .ID_WIDTH         (ID_WIDTH),
        .CAPACITY         (CAPACITY),
        .DATA_WIDTH       (DATA_WIDTH)
    ) u_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .cell_data_o      (cell_data),
        .cell_used_o      (cell_used)
    );

    // The search only reads stored state and runs beside the other ports
    id_queue_exists_search #(
        .CAPACITY    (CAPACITY),
        .DATA_WIDTH  (DATA_WIDTH)
    ) u_exists (
        .cell_data_i (cell_data),
        .cell_used_i (cell_used),
        .req_i       (exists_req_i),
        .data_i      (exists_data_i),
        .mask_i      (exists_mask_i),
        .match_o     (exists_o)
    );

    // Exists is answered in the same cycle, so every request is granted
    assign exists_gnt_o = exists_req_i;

endmodule

`default_nettype wire

/* bench/tb_id_queue.sv */
// ====================
// ID queue testbench
// Applies a table of port values and checks every response against it
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_id_queue;

    localparam int IdWidth     = 2;
    localparam int DataWidth   = 8;
    localparam int ResetCycles = 8;

    // Inputs of one cycle and the responses expected in that same cycle
    typedef struct packed {
        logic                 inp_req;
        logic [IdWidth-1:0]   inp_id;
        logic [DataWidth-1:0] inp_data;
        logic                 oup_req;
        logic [IdWidth-1:0]   oup_id;
        logic                 oup_pop;
        logic                 ex_req;
        logic [DataWidth-1:0] ex_data;
        logic [DataWidth-1:0] ex_mask;
        logic                 exp_inp_gnt;
        logic                 exp_oup_gnt;
        logic                 exp_valid;
        logic [DataWidth-1:0] exp_data;
        logic                 exp_exists;
    } step_t;

    logic clk_i, rst_ni;
    logic inp_req_i, inp_gnt_o, oup_req_i, oup_pop_i, oup_gnt_o, oup_data_valid_o;
    logic exists_req_i, exists_gnt_o, exists_o;
    logic [IdWidth-1:0]   inp_id_i, oup_id_i;
    logic [DataWidth-1:0] inp_data_i, oup_data_o, exists_data_i, exists_mask_i;

    step_t steps[$];
    int    pass_count, fail_count, cycle_count;
    bit    step_ok;

    id_queue #(.ID_WIDTH(IdWidth), .CAPACITY(4), .DATA_WIDTH(DataWidth)) UUT (
        .clk_i, .rst_ni, .inp_req_i, .inp_id_i, .inp_data_i, .inp_gnt_o,
        .exists_req_i, .exists_data_i, .exists_mask_i, .exists_gnt_o, .exists_o,
        .oup_req_i, .oup_id_i, .oup_pop_i, .oup_gnt_o, .oup_data_o, .oup_data_valid_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Columns: push req, id, data | output req, id, pop | exists req, data, mask |
    // expected push gnt, output gnt, valid, data, exists
    task automatic add_row(input logic ir, input logic [IdWidth-1:0] iid,
                           input logic [DataWidth-1:0] idat, input logic orq,
                           input logic [IdWidth-1:0] oid, input logic op, input logic er,
                           input logic [DataWidth-1:0] ed, input logic [DataWidth-1:0] em,
                           input logic ig, input logic og, input logic ov,
                           input logic [DataWidth-1:0] od, input logic ex);
        steps.push_back({ir, iid, idat, orq, oid, op, er, ed, em, ig, og, ov, od, ex});
    endtask

    // Wrong values are reported at once and mark the running step as failed
    task automatic compare_value(input int idx, input string name,
                                 input logic [DataWidth-1:0] got,
                                 input logic [DataWidth-1:0] exp);
        assert (got === exp)
            else begin
                $display("Mismatch at %0t ns: step %0d %s is %0h, expected %0h",
                         $time, idx, name, got, exp);
                step_ok = 1'b0;
            end
    endtask

    initial begin : watchdog
        int limit;
        @(posedge clk_i);
        // Reset, one cycle per table row and some slack
        limit = ResetCycles + steps.size() + 20;
        cycle_count = 1;
        while (cycle_count < limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        step_t s;
        {inp_req_i, inp_id_i, inp_data_i, oup_req_i, oup_id_i, oup_pop_i} = '0;
        {exists_req_i, exists_data_i, exists_mask_i} = '0;
        rst_ni = 1'b0;
        // Reset state, empty peeks on two IDs
        add_row('0, 2'd0, 8'h00, '1, 2'd0, '0, '0, 8'h00, 8'h00, '1, '1, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd3, '0, '0, 8'h00, 8'h00, '1, '1, '0, 8'h00, '0);
        // Interleaved IDs 1 and 2, peeks keep elements and pops remove them
        add_row('1, 2'd1, 8'h11, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd2, 8'h21, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd1, 8'h12, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '0, '0, 8'h00, 8'h00, '1, '1, '1, 8'h11, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '0, '0, 8'h00, 8'h00, '1, '1, '1, 8'h11, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd2, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h21, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h11, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd2, '0, '0, 8'h00, 8'h00, '1, '1, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '0, '0, 8'h00, 8'h00, '1, '1, '1, 8'h12, '0);
        // Fill all four cells, then refused pushes leave the contents alone
        add_row('1, 2'd3, 8'h31, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd1, 8'h13, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd0, 8'h01, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd2, 8'h22, '0, 2'd0, '0, '0, 8'h00, 8'h00, '0, '0, '0, 8'h00, '0);
        add_row('1, 2'd2, 8'h23, '1, 2'd3, '0, '0, 8'h00, 8'h00, '0, '1, '1, 8'h31, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '1, '0, 8'h00, 8'h00, '0, '1, '1, 8'h12, '0);
        // An accepted push blocks the pop of the same cycle
        add_row('1, 2'd2, 8'h24, '1, 2'd1, '1, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '0, '0, 8'h00, 8'h00, '0, '1, '1, 8'h13, '0);
        // Masked search hits, full-mask miss, no request, then a popped value
        add_row('0, 2'd0, 8'h00, '0, 2'd0, '0, '1, 8'h30, 8'hf0, '0, '0, '0, 8'h00, '1);
        add_row('0, 2'd0, 8'h00, '0, 2'd0, '0, '1, 8'h55, 8'hff, '0, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '0, 2'd0, '0, '0, 8'h31, 8'hff, '0, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd3, '1, '1, 8'h31, 8'hff, '0, '1, '1, 8'h31, '1);
        add_row('0, 2'd0, 8'h00, '0, 2'd0, '0, '1, 8'h31, 8'hff, '1, '0, '0, 8'h00, '0);
        // Empty ID 0, refill it through freed cells and drain everything
        add_row('0, 2'd0, 8'h00, '1, 2'd0, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h01, '0);
        add_row('1, 2'd0, 8'h02, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('1, 2'd0, 8'h03, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd0, '1, '0, 8'h00, 8'h00, '0, '1, '1, 8'h02, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd0, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h03, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd0, '1, '0, 8'h00, 8'h00, '1, '1, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd1, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h13, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd2, '1, '0, 8'h00, 8'h00, '1, '1, '1, 8'h24, '0);
        // A zero mask matches any occupied cell, but only once one exists
        add_row('0, 2'd0, 8'h00, '1, 2'd2, '0, '1, 8'h00, 8'h00, '1, '1, '0, 8'h00, '0);
        add_row('1, 2'd3, 8'h35, '0, 2'd0, '0, '1, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);
        add_row('0, 2'd0, 8'h00, '1, 2'd3, '1, '1, 8'h00, 8'h00, '1, '1, '1, 8'h35, '1);
        add_row('0, 2'd0, 8'h00, '0, 2'd0, '0, '0, 8'h00, 8'h00, '1, '0, '0, 8'h00, '0);

        repeat (ResetCycles) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            @(posedge clk_i);
            {inp_req_i, inp_id_i, inp_data_i} <= {s.inp_req, s.inp_id, s.inp_data};
            {oup_req_i, oup_id_i, oup_pop_i}  <= {s.oup_req, s.oup_id, s.oup_pop};
            {exists_req_i, exists_data_i, exists_mask_i} <= {s.ex_req, s.ex_data, s.ex_mask};
            // Responses are combinational and settled by the falling edge
            @(negedge clk_i);
            step_ok = 1'b1;
            compare_value(i, "inp_gnt_o", inp_gnt_o, s.exp_inp_gnt);
            compare_value(i, "oup_gnt_o", oup_gnt_o, s.exp_oup_gnt);
            compare_value(i, "oup_data_valid_o", oup_data_valid_o, s.exp_valid);
            compare_value(i, "oup_data_o", oup_data_o, s.exp_data);
            compare_value(i, "exists_o", exists_o, s.exp_exists);
            compare_value(i, "exists_gnt_o", exists_gnt_o, s.ex_req);
            if (step_ok) pass_count++;
            else fail_count++;
            $display("Step %0d %s", i, step_ok ? "passed" : "failed");
        end
        $display("Steps passed: %0d, steps failed: %0d", pass_count, fail_count);
        if (fail_count == 0) $display("RESULT: PASS");
        else $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* id_queue.f */
verilog/id_queue_pkg.sv
verilog/id_queue_first_free.sv
verilog/id_queue_id_lookup.sv
verilog/id_queue_exists_search.sv
verilog/id_queue_ctrl.sv
verilog/id_queue.sv
bench/tb_id_queue.sv
